/* flist.f */
+incdir+test
verilog/acsi_pkg.sv
verilog/acsi_cmd_buffer.sv
verilog/acsi_ctrl.sv
verilog/acsi_status_port.sv
verilog/acsi_top.sv
test/acsi_tb.sv

/* test/acsi_tb_tasks.svh */
//==========================================================================
// stimulus tasks of the ACSI testbench, included in the testbench module
// CPU byte writes, IO controller readout and replies, and the model of
// the expected command bytes, irq and busy
//==========================================================================

// 32-bit xorshift step for parameter bytes
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// command length of an opcode group
function automatic int cmd_length(input logic [7:0] op);
	if (op <= 8'h1f)
		return 6;
	else if (op <= 8'h5f)
		return 10;
	else if ((op >= 8'h80) && (op <= 8'h9f))
		return 16;
	return 12;
endfunction

// one-cycle CPU write, two in a row are back to back
task automatic write_byte(input logic a0, input logic [7:0] data, input logic [1:0] kind);
	cpu_sel = 1'b1;
	cpu_rw = 1'b0;
	cpu_addr = {1'b0, a0};
	cpu_din = data;
	wr_kind = kind;
	@(negedge clk);
	cpu_sel = 1'b0;
	wr_kind = CHK_NONE;
endtask

// whole command, the escape first when icd is set
task automatic send_cmd(input logic [2:0] tgt, input logic [7:0] op, input logic icd,
		input logic fast_tail);
	int len;
	logic [1:0] kind;
	logic [7:0] data;
	len = cmd_length(op);
	exp_target = tgt;
	if (icd) begin
		write_byte(1'b0, {tgt, 5'h1f}, enable[tgt] ? CHK_IRQ : CHK_QUIET);
		@(negedge clk);
	end
	for (int i = 0; i < len; i++) begin
		data = op;
		if (i > 0) begin
			rng = xorshift32(rng);
			data = rng[7:0];
		end
		// a plain opcode keeps only its low five bits
		exp_bytes[i] = ((i == 0) && !icd) ? {3'b000, op[4:0]} : data;
		if (!enable[tgt])
			kind = CHK_QUIET;
		else
			kind = (i == len - 1) ? CHK_LAST : CHK_IRQ;
		if ((i == 0) && !icd)
			write_byte(1'b0, {tgt, op[4:0]}, kind);
		else
			write_byte(1'b1, data, kind);
		// fast tail leaves irq of the second last byte standing
		if (!(fast_tail && (i == len - 2)))
			@(negedge clk);
	end
	exp_busy = enable[tgt];
	exp_irq = enable[tgt] && fast_tail;
endtask

// registered readout, checked one clock after the select
task automatic read_sel(input logic [4:0] sel, input logic [7:0] expected);
	status_sel = sel;
	exp_byte = expected;
	rd_check = 1'b1;
	@(negedge clk);
	rd_check = 1'b0;
	@(negedge clk);
endtask

task automatic readout(input int n);
	for (int i = 0; i < n; i++)
		read_sel(5'(i), exp_bytes[i]);
	read_sel(5'd16, {exp_target, 4'b0000, exp_busy});
endtask

// IO controller reply, only ack changes irq and the CPU status
task automatic reply(input logic is_ack, input logic [7:0] status);
	dma_status = status;
	dma_ack = is_ack;
	dma_nak = !is_ack;
	if (is_ack) begin
		exp_irq = 1'b1;
		exp_dout = status;
	end
	exp_busy = 1'b0;
	@(negedge clk);
	dma_ack = 1'b0;
	dma_nak = 1'b0;
	@(negedge clk);
endtask

task automatic level_check();
	lvl_check = 1'b1;
	@(negedge clk);
	lvl_check = 1'b0;
endtask

// CPU read strobe, clears irq
task automatic cpu_read();
	cpu_sel = 1'b1;
	cpu_rw = 1'b1;
	@(negedge clk);
	cpu_sel = 1'b0;
	cpu_rw = 1'b0;
	exp_irq = 1'b0;
	level_check();
endtask

/* test/acsi_tb.sv */
//==========================================================================
// testbench of the ACSI hard-disk host adapter
// writes commands from the CPU side, reads them back on the IO controller
// side and replies with ack or nak; concurrent assertions do the checks
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module acsi_tb;
	localparam int NUM_TESTS = 6;
	// three 16-byte commands with full readout
	localparam int MAX_TEST_CYCLES = 3 * 80;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * MAX_TEST_CYCLES * 2;
	localparam logic [31:0] SEED = 32'd64994;
	// expectation attached to a written byte
	localparam logic [1:0] CHK_NONE = 2'd0;
	localparam logic [1:0] CHK_IRQ = 2'd1;
	localparam logic [1:0] CHK_LAST = 2'd2;
	localparam logic [1:0] CHK_QUIET = 2'd3;

	logic clk, reset, cpu_sel, cpu_rw, irq, busy, dma_ack, dma_nak;
	logic [1:0] cpu_addr;
	logic [4:0] status_sel;
	logic [7:0] enable, cpu_din, cpu_dout, dma_status, status_byte;
	// model state and check strobes
	logic [1:0] wr_kind;
	logic rd_check, lvl_check, exp_irq, exp_busy;
	logic [2:0] exp_target;
	logic [7:0] exp_byte, exp_dout;
	logic [7:0] exp_bytes [0:15];
	logic [31:0] rng;
	string test_name;
	int errors = 0;
	int errors_at_start = 0;
	int tests_done = 0;
	int cycle_count = 0;

	acsi_top acsi_top_inst (.*);

	`include "acsi_tb_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	// a byte before the last gives irq two clocks later while busy stays low
	byte_irq: assert property (@(posedge clk) disable iff (reset)
		(wr_kind == CHK_IRQ) |-> ##2 (irq && !busy))
	else begin
		errors++;
		$display("Error %s: irq/busy expected 1/0 actual %b/%b", test_name,
			$sampled(irq), $sampled(busy));
	end
	byte_last: assert property (@(posedge clk) disable iff (reset)
		(wr_kind == CHK_LAST) |-> ##2 busy)
	else begin
		errors++;
		$display("Error %s: busy expected 1 actual %b", test_name, $sampled(busy));
	end
	byte_quiet: assert property (@(posedge clk) disable iff (reset)
		(wr_kind == CHK_QUIET) |-> ##2 (!irq && !busy))
	else begin
		errors++;
		$display("Error %s: irq/busy expected 0/0 actual %b/%b", test_name,
			$sampled(irq), $sampled(busy));
	end
	readout_value: assert property (@(posedge clk) disable iff (reset)
		rd_check |=> (status_byte == exp_byte))
	else begin
		errors++;
		$display("Error %s: status_byte expected %h actual %h", test_name,
			$sampled(exp_byte), $sampled(status_byte));
	end
	// ack and nak are only pulsed while busy
	ack_reply: assert property (@(posedge clk) disable iff (reset)
		dma_ack |=> (irq && !busy && (cpu_dout == exp_dout)))
	else begin
		errors++;
		$display("Error %s: irq/busy/dout expected 1/0/%h actual %b/%b/%h", test_name,
			$sampled(exp_dout), $sampled(irq), $sampled(busy), $sampled(cpu_dout));
	end
	nak_reply: assert property (@(posedge clk) disable iff (reset)
		dma_nak |=> ((irq == exp_irq) && !busy && (cpu_dout == exp_dout)))
	else begin
		errors++;
		$display("Error %s: irq/busy/dout expected %b/0/%h actual %b/%b/%h", test_name,
			$sampled(exp_irq), $sampled(exp_dout), $sampled(irq), $sampled(busy),
			$sampled(cpu_dout));
	end
	levels: assert property (@(posedge clk) disable iff (reset)
		lvl_check |-> ((irq == exp_irq) && (busy == exp_busy) && (cpu_dout == exp_dout)))
	else begin
		errors++;
		$display("Error %s: irq/busy/dout expected %b/%b/%h actual %b/%b/%h", test_name,
			$sampled(exp_irq), $sampled(exp_busy), $sampled(exp_dout),
			$sampled(irq), $sampled(busy), $sampled(cpu_dout));
	end

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		tests_done++;
		$display("test %s done, %0d errors", test_name, errors - errors_at_start);
	endtask

	initial begin
		reset = 1'b1;
		// target 6 disabled
		enable = 8'hbf;
		{cpu_sel, cpu_rw, cpu_addr, cpu_din} = '0;
		{dma_ack, dma_nak, dma_status, status_sel} = '0;
		{wr_kind, rd_check, lvl_check, exp_byte} = '0;
		{exp_irq, exp_busy, exp_target, exp_dout} = '0;
		rng = SEED;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		begin_test("six_byte");
		send_cmd(3'd3, 8'h08, 1'b0, 1'b0);
		readout(6);
		end_test();

		begin_test("length_groups");
		rng = xorshift32(rng);
		send_cmd(3'd1, 8'h20 + {2'b00, rng[5:0]}, 1'b1, 1'b0);
		readout(10);
		send_cmd(3'd0, 8'hc0 + {2'b00, rng[13:8]}, 1'b1, 1'b0);
		readout(12);
		send_cmd(3'd7, 8'h80 + {3'b000, rng[20:16]}, 1'b1, 1'b0);
		readout(16);
		end_test();

		begin_test("icd_escape");
		send_cmd(3'd5, 8'h15, 1'b1, 1'b0);
		readout(6);
		end_test();

		begin_test("disabled_target");
		send_cmd(3'd6, 8'h0a, 1'b0, 1'b0);
		readout(0);
		level_check();
		end_test();

		begin_test("ack_nak");
		send_cmd(3'd2, 8'h0a, 1'b0, 1'b0);
		rng = xorshift32(rng);
		reply(1'b1, rng[7:0]);
		level_check();
		cpu_read();
		send_cmd(3'd2, 8'h0b, 1'b0, 1'b1);
		level_check();
		reply(1'b0, rng[15:8]);
		cpu_read();
		end_test();

		begin_test("range_overflow");
		send_cmd(3'd4, 8'h90, 1'b1, 1'b0);
		repeat (3) begin
			write_byte(1'b1, 8'h5a, CHK_NONE);
			@(negedge clk);
		end
		// dropped bytes land neither in byte 15 nor in a wrapped slot
		readout(16);
		level_check();
		for (int s = 17; s < 32; s++)
			read_sel(5'(s), 8'h00);
		end_test();

		repeat (3) @(negedge clk);
		$display("tests run %0d, errors %0d", tests_done, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/acsi_top.sv */
//==========================================================================
// ACSI hard-disk host adapter
// CPU register port on one side, IO controller request and readout port
// on the other; only a0 of the CPU address is decoded
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module acsi_top (
	input  logic       clk,
	input  logic       reset,

	// enable bit per ACSI target
	input  logic [7:0] enable,

	// CPU register pair
	input  logic       cpu_sel,
	input  logic       cpu_rw,
	input  logic [1:0] cpu_addr,
	input  logic [7:0] cpu_din,
	output logic [7:0] cpu_dout,
	output logic       irq,

	// IO controller side
	output logic       busy,
	input  logic       dma_ack,
	input  logic       dma_nak,
	input  logic [7:0] dma_status,
	input  logic [4:0] status_sel,
	output logic [7:0] status_byte
);
	import acsi_pkg::*;

	cpu_bus_t                    cpu_bus;
	byte_event_t                 byte_event;
	logic [CMD_BYTES-1:0][7:0]   cmd_bytes;
	logic [2:0]                  target;

	// a1 is not decoded by the adapter
	assign cpu_bus = '{sel: cpu_sel, rw: cpu_rw, addr: cpu_addr[0], din: cpu_din};

	acsi_cmd_buffer cmd_buffer_inst (
		.clk       (clk),
		.reset     (reset),
		.cpu       (cpu_bus),
		.event_out (byte_event),
		.cmd_bytes (cmd_bytes),
		.target    (target)
	);

	acsi_ctrl ctrl_inst (
		.clk      (clk),
		.reset    (reset),
		.cpu      (cpu_bus),
		.event_in (byte_event),
		.enable   (enable),
		.dma_ack  (dma_ack),
		.dma_nak  (dma_nak),
		.irq      (irq),
		.busy     (busy)
	);

	acsi_status_port status_port_inst (
		.clk         (clk),
		.reset       (reset),
		.cmd_bytes   (cmd_bytes),
		.target      (target),
		.busy        (busy),
		.status_sel  (status_sel),
		.dma_ack     (dma_ack),
		.dma_status  (dma_status),
		.status_byte (status_byte),
		.cpu_dout    (cpu_dout)
	);

endmodule

`default_nettype wire

/* verilog/acsi_status_port.sv */
//==========================================================================
// ACSI readout port
// registered multiplexer that shows command bytes and the status byte
// to the IO controller, and the DMA status latched on an accepted ack
// that the CPU reads back
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module acsi_status_port (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [acsi_pkg::CMD_BYTES-1:0][7:0] cmd_bytes,
	input  logic [2:0]                          target,
	input  logic                                busy,
	input  logic [4:0]                          status_sel,
	input  logic                                dma_ack,
	input  logic [7:0]                          dma_status,
	output logic [7:0]                          status_byte,
	output logic [7:0]                          cpu_dout
);
	import acsi_pkg::*;

	logic [7:0] sel_byte;

	always_comb begin
		if (status_sel < CMD_BYTES)
			sel_byte = cmd_bytes[status_sel[3:0]];
		else if (status_sel == STATUS_SEL)
			// target on top and the request flag at bit 0
			sel_byte = {target, 4'b0000, busy};
		else
			sel_byte = 8'h00;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			status_byte <= 8'h00;
			cpu_dout <= 8'h00;
		end else begin
			status_byte <= sel_byte;
			// keep the status that came with the last accepted ack
			if (dma_ack && busy)
				cpu_dout <= dma_status;
		end
	end

endmodule

`default_nettype wire

/* verilog/acsi_ctrl.sv */
//==========================================================================
// ACSI controller FSM
// turns byte events into interrupt acknowledges and the busy request
// towards the IO controller and handles its ack and nak replies
// any CPU access clears the interrupt
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module acsi_ctrl (
	input  logic                  clk,
	input  logic                  reset,
	input  acsi_pkg::cpu_bus_t    cpu,
	input  acsi_pkg::byte_event_t event_in,
	input  logic [7:0]            enable,
	input  logic                  dma_ack,
	input  logic                  dma_nak,
	output logic                  irq,
	output logic                  busy
);
	import acsi_pkg::*;

	acsi_state_e state;
	acsi_state_e state_next;
	logic        irq_set;
	logic        reply;
	logic        new_cmd;

	// replies only count while a request is pending
	assign reply = busy && (dma_ack || dma_nak);

	// a first byte restarts the FSM from any state
	assign new_cmd = event_in.valid && event_in.first;

	always_comb begin
		state_next = state;
		// an accepted ack signals the end of the transfer
		irq_set = busy && dma_ack;

		if (reply)
			state_next = st_idle;

		if (new_cmd) begin
			if (enable[event_in.target]) begin
				// first byte of an enabled target is acknowledged too
				state_next = st_collect;
				irq_set = 1'b1;
			end else begin
				state_next = st_ignored;
			end
		end else if (event_in.valid && (state == st_collect)) begin
			if (event_in.last) begin
				// the complete command goes to the IO controller
				state_next = st_request;
			end else begin
				irq_set = 1'b1;
			end
		end
		// bytes in st_idle, st_request and st_ignored are dropped here
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			irq <= 1'b0;
			busy <= 1'b0;
		end else begin
			state <= state_next;
			busy <= (state_next == st_request);
			// a set in the same cycle as a CPU strobe wins
			if (irq_set)
				irq <= 1'b1;
			else if (cpu.sel)
				irq <= 1'b0;
		end
	end

	// a disabled target never gets an interrupt
	no_irq_ignored: assert property (
		@(posedge clk) disable iff (reset)
		(state == st_ignored) && !new_cmd |=> !$rose(irq)
	);

endmodule

`default_nettype wire

/* verilog/acsi_cmd_buffer.sv */
//==========================================================================
// ACSI command capture
// stores the command bytes written by the CPU, keeps the target and the
// write index and decodes the command length from byte 0
// every accepted write is reported one clock later as a byte event
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module acsi_cmd_buffer (
	input  logic                                clk,
	input  logic                                reset,
	input  acsi_pkg::cpu_bus_t                  cpu,
	output acsi_pkg::byte_event_t               event_out,
	output logic [acsi_pkg::CMD_BYTES-1:0][7:0] cmd_bytes,
	output logic [2:0]                          target
);
	import acsi_pkg::*;

	// next free slot, CMD_BYTES once the buffer is full
	logic [4:0]  wr_idx;
	logic        wr_strobe;
	logic        wr_first;
	logic        wr_store;
	logic        icd;
	acsi_group_e group;
	logic [4:0]  last_idx;
	byte_event_t event_next;

	// a write is sel high with rw low
	assign wr_strobe = cpu.sel && !cpu.rw;

	// a0 low starts a new command
	assign wr_first = wr_strobe && !cpu.addr;

	// further bytes only while a slot is left, the rest is dropped
	assign wr_store = wr_strobe && cpu.addr && (wr_idx < CMD_BYTES);

	assign icd = (cpu.din[4:0] == ICD_ESCAPE);

	// opcode group of the stored opcode
	always_comb begin
		if (cmd_bytes[0] <= 8'h1f)
			group = grp_6;
		else if (cmd_bytes[0] <= 8'h5f)
			group = grp_10;
		else if ((cmd_bytes[0] >= 8'h80) && (cmd_bytes[0] <= 8'h9f))
			group = grp_16;
		else
			group = grp_12;
	end

	// index of the byte that completes the command
	always_comb begin
		case (group)
			grp_6:   last_idx = 5'd5;
			grp_10:  last_idx = 5'd9;
			grp_16:  last_idx = 5'd15;
			default: last_idx = 5'd11;
		endcase
	end

	// event for the write in this cycle
	always_comb begin
		event_next = '0;
		if (wr_first) begin
			event_next.valid = 1'b1;
			event_next.first = 1'b1;
			event_next.target = cpu.din[7:5];
		end else if (wr_store) begin
			event_next.valid = 1'b1;
			event_next.target = target;
			// index 0 is never the last one, so a stale group there is harmless
			event_next.last = (wr_idx == last_idx);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_idx <= '0;
			target <= '0;
			event_out <= '0;
		end else begin
			event_out <= event_next;
			if (wr_first) begin
				target <= cpu.din[7:5];
				// after an escape the next byte is the real opcode
				wr_idx <= icd ? 5'd0 : 5'd1;
			end else if (wr_store) begin
				wr_idx <= wr_idx + 5'd1;
			end
		end
	end

	// command bytes
	always_ff @(posedge clk) begin
		if (wr_first && !icd)
			// plain opcode sits in the low five bits of the first byte
			cmd_bytes[0] <= {3'b000, cpu.din[4:0]};
		else if (wr_store)
			cmd_bytes[wr_idx[3:0]] <= cpu.din;
	end

	// saturation of the write index
	idx_in_range: assert property (
		@(posedge clk) disable iff (reset)
		wr_idx <= CMD_BYTES
	);

endmodule

`default_nettype wire

/* verilog/acsi_pkg.sv */
//==========================================================================
// shared types and constants of the ACSI hard-disk host adapter
// imported by the command buffer, the controller FSM, the readout port
// and the top level that ties them together
//==========================================================================
`default_nettype none

package acsi_pkg;

	// depth of the command buffer, set by the longest command
	localparam int CMD_BYTES = 16;

	// readout select index of the status byte, right after the last command byte
	localparam int STATUS_SEL = 16;

	// opcode field value of an ICD escape, real opcode follows in the next byte
	localparam logic [4:0] ICD_ESCAPE = 5'h1f;

	// one CPU access strobe, valid for a single clock
	typedef struct packed {
		// chip select of the ACSI register pair
		logic       sel;
		// high for a read
		logic       rw;
		// a0 of the access, low marks the first command byte
		logic       addr;
		logic [7:0] din;
	} cpu_bus_t;

	// opcode groups, each one fixes the command length
	typedef enum logic [1:0] {
		grp_6  = 2'd0,
		grp_10 = 2'd1,
		grp_16 = 2'd2,
		grp_12 = 2'd3
	} acsi_group_e;

	// one accepted command byte, from the buffer to the controller
	typedef struct packed {
		logic       valid;
		// written with a0 low
		logic       first;
		// target in force after this write
		logic [2:0] target;
		// this byte completes the command
		logic       last;
	} byte_event_t;

	// controller states
	typedef enum logic [1:0] {
		st_idle    = 2'd0,
		st_collect = 2'd1,
		st_request = 2'd2,
		st_ignored = 2'd3
	} acsi_state_e;

endpackage

`default_nettype wire
